// ==== fetch_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths and codes of the fetch front end
// Enums are 2-bit encoded and must match the retire port width
////////////////////////////////////////////////////////////

package fetch_pkg;

	// Instruction and address width
	localparam int insn_w = 32;

	// Major opcode field values, bits 31:26
	localparam logic [5:0] opc_jump = 6'h00;
	localparam logic [5:0] opc_nop  = 6'h05;
	localparam logic [5:0] opc_mul  = 6'h06;

	// Filler word for squashed or faulted fetches
	localparam logic [insn_w-1:0] nop_insn = {opc_nop, 26'h041_0000};

	// Error tags from the instruction memory
	localparam logic [3:0] tag_te = 4'hd;
	localparam logic [3:0] tag_pe = 4'hc;
	localparam logic [3:0] tag_be = 4'hb;

	// Instruction class seen by the decoder
	typedef enum logic [1:0] {
		op_jump,
		op_nop,
		op_mul,
		op_alu
	} opcode_e;

	// Fetch exception carried with a word
	typedef enum logic [1:0] {
		exc_none,
		exc_itlb,
		exc_immu,
		exc_bus
	} exc_e;

endpackage

// ==== fetch_top.sv ====
////////////////////////////////////////////////////////////
// Fetch front end top, PC generator to buffer to decoder
// Memory port is four-phase req/ack; MUL_CYCLES must be >= 1
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_top
	import fetch_pkg::*;
#(
	parameter logic [insn_w-1:0] RESET_PC   = 32'h0000_0100,
	parameter logic [insn_w-1:0] EXC_VECTOR = 32'h0000_0800,
	parameter int                MUL_CYCLES = 3
) (
	input  logic              clk,
	input  logic              rst_n_i,
	// Instruction memory
	input  logic              fetch_ack_i,
	input  logic              fetch_err_i,
	input  logic [insn_w-1:0] fetch_dat_i,
	input  logic [3:0]        fetch_tag_i,
	output logic              fetch_req_o,
	output logic [insn_w-1:0] fetch_adr_o,
	// Retire
	output logic              retire_valid_o,
	output logic [insn_w-1:0] retire_pc_o,
	output logic [insn_w-1:0] retire_insn_o,
	output opcode_e           retire_op_o,
	output exc_e              retire_exc_o
);

	// Buffer link
	logic              slot_free;
	logic              slot_valid;
	logic [insn_w-1:0] slot_insn;
	logic [insn_w-1:0] slot_pc;
	exc_e              slot_exc;
	logic              slot_take;

	// Flush path
	logic              redirect;
	logic [insn_w-1:0] redirect_pc;

	pc_gen #(
		.RESET_PC(RESET_PC)
	) u_pc_gen (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.slot_free_i  (slot_free),
		.redirect_i   (redirect),
		.redirect_pc_i(redirect_pc),
		.fetch_ack_i  (fetch_ack_i),
		.fetch_err_i  (fetch_err_i),
		.fetch_req_o  (fetch_req_o),
		.fetch_adr_o  (fetch_adr_o)
	);

	// Sees the same req/adr that goes out to memory
	if_stage u_if_stage (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.fetch_req_i (fetch_req_o),
		.fetch_adr_i (fetch_adr_o),
		.fetch_ack_i (fetch_ack_i),
		.fetch_err_i (fetch_err_i),
		.fetch_dat_i (fetch_dat_i),
		.fetch_tag_i (fetch_tag_i),
		.slot_take_i (slot_take),
		.redirect_i  (redirect),
		.slot_free_o (slot_free),
		.slot_valid_o(slot_valid),
		.slot_insn_o (slot_insn),
		.slot_pc_o   (slot_pc),
		.slot_exc_o  (slot_exc)
	);

	insn_decode #(
		.EXC_VECTOR(EXC_VECTOR),
		.MUL_CYCLES(MUL_CYCLES)
	) u_insn_decode (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.slot_valid_i  (slot_valid),
		.slot_insn_i   (slot_insn),
		.slot_pc_i     (slot_pc),
		.slot_exc_i    (slot_exc),
		.slot_take_o   (slot_take),
		.redirect_o    (redirect),
		.redirect_pc_o (redirect_pc),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o   (retire_pc_o),
		.retire_insn_o (retire_insn_o),
		.retire_op_o   (retire_op_o),
		.retire_exc_o  (retire_exc_o)
	);

endmodule

// ==== if_stage.sv ====
////////////////////////////////////////////////////////////
// Single-entry fetch buffer between memory and decoder
// Relies on the master keeping only one fetch in flight
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module if_stage
	import fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              fetch_req_i,
	input  logic [insn_w-1:0] fetch_adr_i,
	input  logic              fetch_ack_i,
	input  logic              fetch_err_i,
	input  logic [insn_w-1:0] fetch_dat_i,
	input  logic [3:0]        fetch_tag_i,
	input  logic              slot_take_i,
	input  logic              redirect_i,
	output logic              slot_free_o,
	output logic              slot_valid_o,
	output logic [insn_w-1:0] slot_insn_o,
	output logic [insn_w-1:0] slot_pc_o,
	output exc_e              slot_exc_o
);

	logic              accept;
	logic              keep;
	logic              slot_valid_q;
	logic              squash_q;
	logic [insn_w-1:0] insn_q;
	logic [insn_w-1:0] pc_q;
	exc_e              exc_q;
	exc_e              tag_exc;

	// The one cycle where a word is handed over
	assign accept = fetch_req_i & (fetch_ack_i | fetch_err_i);

	// Drop words fetched down the wrong path
	// A redirect in the accept cycle kills that word directly
	assign keep = accept & ~squash_q & ~redirect_i;

	//////////////////////////////////////////////////////////
	// Error tag decode
	//////////////////////////////////////////////////////////
	always_comb begin
		case (fetch_tag_i)
			tag_te:  tag_exc = exc_itlb;
			tag_pe:  tag_exc = exc_immu;
			// tag_be and any unknown tag
			default: tag_exc = exc_bus;
		endcase
	end

	//////////////////////////////////////////////////////////
	// Squash and slot control
	//////////////////////////////////////////////////////////

	// Set when the pipe is flushed under an open request
	// Cleared by the accept that throws the stale word away
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			squash_q <= 1'b0;
		else if (accept)
			squash_q <= 1'b0;
		else if (redirect_i && fetch_req_i)
			squash_q <= 1'b1;
	end

	// Flush wins, then fill, then drain
	// Without take the word just sits here (decoder frozen)
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			slot_valid_q <= 1'b0;
		else if (redirect_i)
			slot_valid_q <= 1'b0;
		else if (keep)
			slot_valid_q <= 1'b1;
		else if (slot_take_i)
			slot_valid_q <= 1'b0;
	end

	// Payload, loaded only on a kept word
	always_ff @(posedge clk) begin
		if (keep) begin
			insn_q <= fetch_err_i ? nop_insn : fetch_dat_i;
			pc_q   <= {fetch_adr_i[insn_w-1:2], 2'b00};
			exc_q  <= fetch_err_i ? tag_exc : exc_none;
		end
	end

	// Room for the next fetch, early when the decoder takes
	assign slot_free_o  = ~slot_valid_q | slot_take_i;

	assign slot_valid_o = slot_valid_q;
	assign slot_insn_o  = insn_q;
	assign slot_pc_o    = pc_q;
	assign slot_exc_o   = exc_q;

endmodule

// ==== insn_decode.sv ====
////////////////////////////////////////////////////////////
// Opcode classify, multiply stall and redirect on jump or fault
// Retire outputs are combinational off the fetch buffer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module insn_decode
	import fetch_pkg::*;
#(
	parameter logic [insn_w-1:0] EXC_VECTOR = 32'h0000_0800,
	parameter int                MUL_CYCLES = 3
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              slot_valid_i,
	input  logic [insn_w-1:0] slot_insn_i,
	input  logic [insn_w-1:0] slot_pc_i,
	input  exc_e              slot_exc_i,
	output logic              slot_take_o,
	output logic              redirect_o,
	output logic [insn_w-1:0] redirect_pc_o,
	output logic              retire_valid_o,
	output logic [insn_w-1:0] retire_pc_o,
	output logic [insn_w-1:0] retire_insn_o,
	output opcode_e           retire_op_o,
	output exc_e              retire_exc_o
);

	localparam int cnt_w = $clog2(MUL_CYCLES + 1);

	opcode_e           op;
	logic              faulted;
	logic              is_mul;
	logic              mul_wait;
	logic              retire;
	logic [cnt_w-1:0]  mul_cnt_q;
	logic [insn_w-1:0] jump_off;

	//////////////////////////////////////////////////////////
	// Classify
	//////////////////////////////////////////////////////////
	always_comb begin
		case (slot_insn_i[31:26])
			opc_jump: op = op_jump;
			opc_nop:  op = op_nop;
			opc_mul:  op = op_mul;
			default:  op = op_alu;
		endcase
	end

	assign faulted = (slot_exc_i != exc_none);

	// Faulted words never stall, they carry nop_insn anyway
	assign is_mul = slot_valid_i & (op == op_mul) & ~faulted;

	//////////////////////////////////////////////////////////
	// Multiply timer
	//////////////////////////////////////////////////////////

	// Zero means idle, loaded on the first cycle a mul sits in the slot
	// Retire once it has counted down to one
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			mul_cnt_q <= '0;
		else if (mul_cnt_q != '0)
			mul_cnt_q <= mul_cnt_q - cnt_w'(1);
		else if (is_mul)
			mul_cnt_q <= cnt_w'(MUL_CYCLES);
	end

	assign mul_wait = is_mul & (mul_cnt_q != cnt_w'(1));
	assign retire   = slot_valid_i & ~mul_wait;

	//////////////////////////////////////////////////////////
	// Redirect
	//////////////////////////////////////////////////////////

	// Word offset, sign extended from 26 bits
	assign jump_off = {{4{slot_insn_i[25]}}, slot_insn_i[25:0], 2'b00};

	assign redirect_o    = retire & (faulted | (op == op_jump));
	// Exception vector beats a jump target
	assign redirect_pc_o = faulted ? EXC_VECTOR : slot_pc_i + jump_off;

	// Take and retire in the same cycle
	assign slot_take_o    = retire;
	assign retire_valid_o = retire;
	assign retire_pc_o    = slot_pc_i;
	assign retire_insn_o  = slot_insn_i;
	assign retire_op_o    = op;
	assign retire_exc_o   = slot_exc_i;

endmodule

// ==== pc_gen.sv ====
////////////////////////////////////////////////////////////
// PC and four-phase fetch master, one request in flight at most
// Memory must drop ack/err only after it sees req low
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pc_gen
	import fetch_pkg::*;
#(
	parameter logic [insn_w-1:0] RESET_PC = 32'h0000_0100
) (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              slot_free_i,
	input  logic              redirect_i,
	input  logic [insn_w-1:0] redirect_pc_i,
	input  logic              fetch_ack_i,
	input  logic              fetch_err_i,
	output logic              fetch_req_o,
	output logic [insn_w-1:0] fetch_adr_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait_ack,
		st_wait_release
	} state_e;

	state_e            state_q;
	logic [insn_w-1:0] pc_q;
	logic [insn_w-1:0] adr_q;
	logic              bus_busy;
	logic              start;

	// Memory still answering a previous request
	assign bus_busy = fetch_ack_i | fetch_err_i;

	// New request only with room in the buffer and a quiet bus
	// A redirect cycle never starts one, pc_q is being reloaded
	assign start = (state_q == st_idle) & slot_free_i & ~redirect_i & ~bus_busy;

	//////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (start)
						state_q <= st_wait_ack;
				end
				// Word accepted this cycle, req drops on this edge
				st_wait_ack: begin
					if (bus_busy)
						state_q <= st_wait_release;
				end
				// Wait for memory to let go of ack/err
				st_wait_release: begin
					if (!bus_busy)
						state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// pc_q is the next address to fetch, stepped when a request starts
	// Redirect overrides at any time; an open handshake still finishes
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			pc_q <= RESET_PC;
		else if (redirect_i)
			pc_q <= redirect_pc_i;
		else if (start)
			pc_q <= pc_q + insn_w'(4);
	end

	// Address frozen for the whole request
	always_ff @(posedge clk) begin
		if (start)
			adr_q <= pc_q;
	end

	assign fetch_req_o = (state_q == st_wait_ack);
	assign fetch_adr_o = adr_q;

endmodule

// ==== project.f ====
fetch_pkg.sv
pc_gen.sv
if_stage.sv
insn_decode.sv
fetch_top.sv
tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_fetch -f project.f --Mdir obj_dir -o tb_fetch
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_fetch > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
	exit 1
fi
if [ $status -ne 0 ] || ! grep -q "TESTBENCH PASSED" "$log"; then
	echo "Simulation did not finish cleanly"
	exit 1
fi
exit 0

// ==== tb_fetch.sv ====
////////////////////////////////////////////////////////////
// Testbench for fetch_top with random memory delays and faults
// Program is a fixed hash of the address, so re-fetches agree
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_fetch
	import fetch_pkg::*;
();

	localparam logic [31:0] reset_pc        = 32'h0000_0100;
	localparam logic [31:0] exc_vector      = 32'h0000_0800;
	localparam int          mul_cycles      = 3;
	localparam int          half_period     = 20;
	localparam int          drive_delay     = 2;
	localparam int          reset_cycles    = 10;
	localparam int          num_retires     = 400;
	// Generous budget of 40 cycles per retire
	localparam int          watchdog_cycles = reset_cycles + num_retires * 40;
	localparam logic [31:0] seed            = 32'd91;

	logic        clk = 1'b0;
	logic        rst_n_i = 1'b0;
	logic        fetch_ack_i;
	logic        fetch_err_i;
	logic [31:0] fetch_dat_i;
	logic [3:0]  fetch_tag_i;
	logic        fetch_req_o;
	logic [31:0] fetch_adr_o;
	logic        retire_valid_o;
	logic [31:0] retire_pc_o;
	logic [31:0] retire_insn_o;
	opcode_e     retire_op_o;
	exc_e        retire_exc_o;

	// Model and monitor state
	logic [31:0] rng_state;
	logic [31:0] model_pc;
	int          retire_cnt;
	int          cycle_cnt;
	int          accept_cycle;
	logic        prev_req;
	logic        prev_busy;
	logic [31:0] prev_adr;

	fetch_top #(
		.RESET_PC  (reset_pc),
		.EXC_VECTOR(exc_vector),
		.MUL_CYCLES(mul_cycles)
	) u_fetch_top (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.fetch_ack_i   (fetch_ack_i),
		.fetch_err_i   (fetch_err_i),
		.fetch_dat_i   (fetch_dat_i),
		.fetch_tag_i   (fetch_tag_i),
		.fetch_req_o   (fetch_req_o),
		.fetch_adr_o   (fetch_adr_o),
		.retire_valid_o(retire_valid_o),
		.retire_pc_o   (retire_pc_o),
		.retire_insn_o (retire_insn_o),
		.retire_op_o   (retire_op_o),
		.retire_exc_o  (retire_exc_o)
	);

	////////////////////////////////////////////////////////////
	// Hashing and the program image
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Multiply spreads every address bit into the top bits
	function automatic logic [31:0] addr_hash(input logic [31:0] adr, input logic [31:0] salt);
		return xorshift32((adr ^ salt ^ seed) * 32'h9e37_79b1);
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		logic [31:0] h;
		logic [3:0]  off;
		logic [31:0] w;
		h   = addr_hash(adr, 32'h0);
		// Short jump, -8..7 words, never onto itself
		off = (h[27:24] == 4'h0) ? 4'h2 : h[27:24];
		case (h[31:28])
			4'h0, 4'h1: w = {6'h00, {22{off[3]}}, off};
			4'h2, 4'h3: w = {6'h06, h[25:0]};
			4'h4:       w = {6'h05, h[25:0]};
			// Opcode 6'h14 and up, always ALU
			default:    w = h;
		endcase
		return w;
	endfunction

	// About one address in sixteen; the vector itself is clean
	function automatic logic mem_fault(input logic [31:0] adr);
		logic [31:0] h;
		h = addr_hash(adr, 32'h5eed_0000);
		return (h[31:28] == 4'h0) && (adr != exc_vector);
	endfunction

	function automatic logic [3:0] mem_tag(input logic [31:0] adr);
		logic [31:0] h;
		logic [3:0]  t;
		h = addr_hash(adr, 32'h5eed_0000);
		case (h[27:26])
			2'd0:    t = 4'hd;
			2'd1:    t = 4'hc;
			2'd2:    t = 4'hb;
			// Not a known code
			default: t = 4'h7;
		endcase
		return t;
	endfunction

	function automatic int rand_delay();
		rng_state = xorshift32(rng_state);
		return int'(rng_state[9:8]);
	endfunction

	////////////////////////////////////////////////////////////
	// Reference rules
	////////////////////////////////////////////////////////////
	function automatic exc_e exc_from_tag(input logic [3:0] tag);
		exc_e e;
		case (tag)
			4'hd:    e = exc_itlb;
			4'hc:    e = exc_immu;
			default: e = exc_bus;
		endcase
		return e;
	endfunction

	function automatic opcode_e class_of(input logic [31:0] insn);
		opcode_e c;
		case (insn[31:26])
			6'h00:   c = op_jump;
			6'h05:   c = op_nop;
			6'h06:   c = op_mul;
			default: c = op_alu;
		endcase
		return c;
	endfunction

	// Signed word offset in the low 26 bits
	function automatic logic [31:0] jump_target(input logic [31:0] pc, input logic [31:0] insn);
		int off_words;
		off_words = int'($signed(insn[25:0]));
		return pc + 32'(off_words * 4);
	endfunction

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			abort_run($sformatf("mismatch %s got %08h expected %08h", name, got, expected));
	endtask

	// Four-phase rules on the memory port
	task automatic check_handshake();
		logic busy;
		busy = fetch_ack_i | fetch_err_i;
		if (fetch_req_o && prev_req)
			check_equal("fetch_adr_o", fetch_adr_o, prev_adr);
		if (fetch_req_o && !prev_req && prev_busy)
			abort_run("fetch_req_o rose while ack or err was still high");
		if (fetch_req_o && prev_req && prev_busy)
			abort_run("fetch_req_o stayed high after the word was accepted");
		// Word handed over at the coming edge
		if (fetch_req_o && busy)
			accept_cycle = cycle_cnt;
		prev_req  = fetch_req_o;
		prev_adr  = fetch_adr_o;
		prev_busy = busy;
	endtask

	task automatic check_retire();
		logic        fault;
		logic [31:0] exp_insn;
		opcode_e     exp_op;
		exc_e        exp_exc;
		int          exp_lat;
		fault    = mem_fault(model_pc);
		exp_insn = fault ? nop_insn : mem_word(model_pc);
		exp_op   = class_of(exp_insn);
		exp_exc  = fault ? exc_from_tag(mem_tag(model_pc)) : exc_none;
		// In the slot one cycle after acceptance, a multiply sits there longer
		exp_lat  = (exp_op == op_mul) ? 1 + mul_cycles : 1;
		check_equal("retire_pc_o", retire_pc_o, model_pc);
		check_equal("retire_insn_o", retire_insn_o, exp_insn);
		check_equal("retire_op_o", 32'(retire_op_o), 32'(exp_op));
		check_equal("retire_exc_o", 32'(retire_exc_o), 32'(exp_exc));
		check_equal("retire_valid_o cycle", 32'(cycle_cnt), 32'(accept_cycle + exp_lat));
		// Next PC
		if (fault)
			model_pc = exc_vector;
		else if (exp_op == op_jump)
			model_pc = jump_target(model_pc, exp_insn);
		else
			model_pc = model_pc + 32'd4;
		retire_cnt = retire_cnt + 1;
	endtask

	////////////////////////////////////////////////////////////
	// Clock, reset and run control
	////////////////////////////////////////////////////////////
	initial begin
		forever #(half_period) clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst_n_i)
			cycle_cnt <= 0;
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	// Everything sampled mid-cycle, away from the edges
	always @(negedge clk) begin
		if (rst_n_i !== 1'b1) begin
			if (retire_valid_o !== 1'b0)
				abort_run("retire_valid_o was not low during reset");
			if (fetch_req_o !== 1'b0)
				abort_run("fetch_req_o was not low during reset");
			model_pc     = reset_pc;
			retire_cnt   = 0;
			accept_cycle = 0;
			prev_req     = 1'b0;
			prev_busy    = 1'b0;
		end else begin
			check_handshake();
			if (retire_valid_o === 1'b1)
				check_retire();
			else if (retire_valid_o !== 1'b0)
				abort_run("retire_valid_o is unknown after reset");
		end
	end

	initial begin
		repeat (reset_cycles) @(posedge clk);
		#(drive_delay);
		rst_n_i = 1'b1;
		while (retire_cnt < num_retires)
			@(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		abort_run($sformatf("timeout with only %0d of %0d instructions retired",
			retire_cnt, num_retires));
	end

	////////////////////////////////////////////////////////////
	// Memory responder
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] adr;
		int          dly;
		fetch_ack_i = 1'b0;
		fetch_err_i = 1'b0;
		fetch_dat_i = '0;
		fetch_tag_i = '0;
		rng_state   = seed;
		wait (rst_n_i === 1'b1);
		forever begin
			@(negedge clk);
			if (fetch_req_o === 1'b1) begin
				adr = fetch_adr_o;
				dly = rand_delay();
				repeat (dly) @(negedge clk);
				@(posedge clk);
				#(drive_delay);
				// Data driven on err too, the DUT must replace it
				fetch_dat_i = mem_word(adr);
				if (mem_fault(adr)) begin
					fetch_err_i = 1'b1;
					fetch_tag_i = mem_tag(adr);
				end else begin
					fetch_ack_i = 1'b1;
					fetch_tag_i = 4'h0;
				end
				// Hold until req is seen low
				@(negedge clk);
				while (fetch_req_o === 1'b1)
					@(negedge clk);
				dly = rand_delay();
				repeat (dly) @(negedge clk);
				@(posedge clk);
				#(drive_delay);
				fetch_ack_i = 1'b0;
				fetch_err_i = 1'b0;
			end
		end
	end

endmodule
